//--- design/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [3:0]  regno_t;
  typedef logic [5:0]  op1_t;
  typedef logic [7:0]  op2_t;
  typedef logic [15:0] imm_t;

  // Field positions inside an instruction word
  localparam int OP1_LSB = 26;
  localparam int OP2_LSB = 18;
  localparam int IMM_LSB = 8;
  localparam int RD_LSB  = 8;
  localparam int RS_LSB  = 4;
  localparam int RT_LSB  = 0;

  localparam word_t INST_BYTES = 32'd4;

  // Primary opcodes
  localparam op1_t OP1_ALUR = 6'b000000;
  localparam op1_t OP1_BEQ  = 6'b001000;
  localparam op1_t OP1_BLT  = 6'b001001;
  localparam op1_t OP1_BLE  = 6'b001010;
  localparam op1_t OP1_BNE  = 6'b001011;
  localparam op1_t OP1_JAL  = 6'b001100;
  localparam op1_t OP1_LW   = 6'b010010;
  localparam op1_t OP1_SW   = 6'b011010;
  localparam op1_t OP1_ADDI = 6'b100000;
  localparam op1_t OP1_ANDI = 6'b100100;
  localparam op1_t OP1_ORI  = 6'b100101;
  localparam op1_t OP1_XORI = 6'b100110;

  // ALU-R functions
  localparam op2_t OP2_NOP  = 8'b00000000;
  localparam op2_t OP2_EQ   = 8'b00001000;
  localparam op2_t OP2_LT   = 8'b00001001;
  localparam op2_t OP2_LE   = 8'b00001010;
  localparam op2_t OP2_NE   = 8'b00001011;
  localparam op2_t OP2_ADD  = 8'b00100000;
  localparam op2_t OP2_AND  = 8'b00100100;
  localparam op2_t OP2_OR   = 8'b00100101;
  localparam op2_t OP2_XOR  = 8'b00100110;
  localparam op2_t OP2_SUB  = 8'b00101000;
  localparam op2_t OP2_NAND = 8'b00101100;
  localparam op2_t OP2_NOR  = 8'b00101101;
  localparam op2_t OP2_NXOR = 8'b00101110;
  localparam op2_t OP2_RSHF = 8'b00110000;
  localparam op2_t OP2_LSHF = 8'b00110001;

  // ALUR with NOP function, all zeros
  localparam inst_t INST_BUBBLE = '0;

  // Instruction classes shared by decode and the interlock
  function automatic logic is_alur(op1_t op1, op2_t op2);
    return (op1 == OP1_ALUR) && (op2 != OP2_NOP);
  endfunction

  function automatic logic is_alui(op1_t op1);
    return (op1 == OP1_ADDI) || (op1 == OP1_ANDI) || (op1 == OP1_ORI) || (op1 == OP1_XORI);
  endfunction

  function automatic logic is_branch(op1_t op1);
    return (op1 == OP1_BEQ) || (op1 == OP1_BLT) || (op1 == OP1_BLE) || (op1 == OP1_BNE);
  endfunction

endpackage

//--- design/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

  // Memory mapped I/O
  localparam logic [31:0] ADDR_HEX = 32'hFFFF_F000;
  localparam logic [31:0] ADDR_KEY = 32'hFFFF_F080;

  localparam int HEX_BITS = 24;
  typedef logic [HEX_BITS-1:0] hex_t;

  localparam int KEY_BITS = 4;
  typedef logic [KEY_BITS-1:0] key_t;

  // Shown on the display until the first store to it
  localparam hex_t HEX_RESET = 24'hFE_DEAD;

  // Defaults for the top level parameters
  localparam logic [31:0] START_PC_DEFAULT   = 32'h0000_0100;
  localparam int          DMEM_WORDS_DEFAULT = 1024;

endpackage

//--- design/fetch_stage.sv
module fetch_stage
  import isa_pkg::*, cpu_cfg_pkg::*;
#(
  parameter word_t START_PC = START_PC_DEFAULT
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  logic  redirect,
  input  word_t target,
  output word_t imem_addr,
  input  inst_t imem_data,
  output inst_t inst_fe,
  output word_t pc_fe
);

  word_t pc;

  assign imem_addr = pc;

  // Redirect wins over stall, squashing whatever was just fetched
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= START_PC;
      inst_fe <= INST_BUBBLE;
    end else if (redirect) begin
      pc      <= target;
      inst_fe <= INST_BUBBLE;
    end else if (!stall) begin
      pc      <= pc + INST_BYTES;
      inst_fe <= imem_data;
    end
  end

  // PC of the latched instruction, only meaningful alongside it
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_fe <= pc;
    end
  end

endmodule

//--- design/decode_stage.sv
module decode_stage
  import isa_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   redirect,
  input  inst_t  inst_fe,
  input  word_t  pc_fe,
  output regno_t rs,
  output regno_t rt,
  input  word_t  rs_val,
  input  word_t  rt_val,
  output op1_t   op1_id,
  output op2_t   op2_id,
  output word_t  a_id,
  output word_t  b_id,
  output word_t  imm_id,
  output word_t  pc_id,
  output regno_t wregno_id,
  output logic   wr_reg_id,
  output logic   rd_mem_id,
  output logic   wr_mem_id,
  output logic   is_br_id,
  output logic   is_jal_id
);

  op1_t   op1;
  op2_t   op2;
  imm_t   imm;
  regno_t rd;
  word_t  imm_ext;
  logic   alur;
  logic   alui;
  logic   is_lw;
  logic   is_sw;
  logic   is_jal;
  logic   wr_reg;
  regno_t wregno;

  // ******************************************************************
  // Field extraction and control decode
  // ******************************************************************
  assign op1 = inst_fe[OP1_LSB +: $bits(op1_t)];
  assign op2 = inst_fe[OP2_LSB +: $bits(op2_t)];
  assign imm = inst_fe[IMM_LSB +: $bits(imm_t)];
  assign rd  = inst_fe[RD_LSB +: $bits(regno_t)];
  assign rs  = inst_fe[RS_LSB +: $bits(regno_t)];
  assign rt  = inst_fe[RT_LSB +: $bits(regno_t)];

  assign imm_ext = {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};

  assign alur   = is_alur(op1, op2);
  assign alui   = is_alui(op1);
  assign is_lw  = (op1 == OP1_LW);
  assign is_sw  = (op1 == OP1_SW);
  assign is_jal = (op1 == OP1_JAL);

  // ALU-R writes rd, everything else that writes uses rt
  assign wr_reg = alur || alui || is_lw || is_jal;
  assign wregno = alur ? rd : rt;

  // ******************************************************************
  // Decode latch
  // ******************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op1_id    <= OP1_ALUR;
      op2_id    <= OP2_NOP;
      wregno_id <= '0;
      wr_reg_id <= 1'b0;
      rd_mem_id <= 1'b0;
      wr_mem_id <= 1'b0;
      is_br_id  <= 1'b0;
      is_jal_id <= 1'b0;
    end else if (stall || redirect) begin
      // Bubble
      op1_id    <= OP1_ALUR;
      op2_id    <= OP2_NOP;
      wregno_id <= '0;
      wr_reg_id <= 1'b0;
      rd_mem_id <= 1'b0;
      wr_mem_id <= 1'b0;
      is_br_id  <= 1'b0;
      is_jal_id <= 1'b0;
    end else begin
      op1_id    <= op1;
      op2_id    <= op2;
      wregno_id <= wregno;
      wr_reg_id <= wr_reg;
      rd_mem_id <= is_lw;
      wr_mem_id <= is_sw;
      is_br_id  <= is_branch(op1);
      is_jal_id <= is_jal;
    end
  end

  always_ff @(posedge clk) begin
    a_id   <= rs_val;
    b_id   <= rt_val;
    imm_id <= imm_ext;
    pc_id  <= pc_fe;
  end

endmodule

//--- design/register_file.sv
module register_file
  import isa_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  regno_t rs,
  input  regno_t rt,
  output word_t  rs_val,
  output word_t  rt_val,
  input  logic   we,
  input  regno_t wregno,
  input  word_t  wdata
);

  localparam int NUM_REGS = 2 ** $bits(regno_t);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wregno] <= wdata;
    end
  end

  // Write-through so decode sees a value written back in the same cycle
  assign rs_val = (we && (wregno == rs)) ? wdata : regs[rs];
  assign rt_val = (we && (wregno == rt)) ? wdata : regs[rt];

endmodule

//--- design/hazard_unit.sv
module hazard_unit
  import isa_pkg::*;
(
  input  inst_t  inst_fe,
  input  regno_t wregno_id,
  input  regno_t wregno_ex,
  input  logic   wr_reg_id,
  input  logic   wr_reg_ex,
  output logic   stall
);

  op1_t   op1;
  op2_t   op2;
  regno_t rs;
  regno_t rt;
  logic   reads_rs;
  logic   reads_rt;
  logic   rs_pending;
  logic   rt_pending;

  assign op1 = inst_fe[OP1_LSB +: $bits(op1_t)];
  assign op2 = inst_fe[OP2_LSB +: $bits(op2_t)];
  assign rs  = inst_fe[RS_LSB +: $bits(regno_t)];
  assign rt  = inst_fe[RT_LSB +: $bits(regno_t)];

  // Which sources the instruction in decode actually reads
  assign reads_rt = is_alur(op1, op2) || is_branch(op1) || (op1 == OP1_SW);
  assign reads_rs = reads_rt || is_alui(op1) || (op1 == OP1_LW) || (op1 == OP1_JAL);

  // Producers in execute and memory, write-back is covered by the register file
  assign rs_pending = (wr_reg_id && (wregno_id == rs)) || (wr_reg_ex && (wregno_ex == rs));
  assign rt_pending = (wr_reg_id && (wregno_id == rt)) || (wr_reg_ex && (wregno_ex == rt));

  assign stall = (reads_rs && rs_pending) || (reads_rt && rt_pending);

endmodule

//--- design/execute_stage.sv
module execute_stage
  import isa_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  op1_t   op1_id,
  input  op2_t   op2_id,
  input  word_t  a_id,
  input  word_t  b_id,
  input  word_t  imm_id,
  input  word_t  pc_id,
  input  regno_t wregno_id,
  input  logic   wr_reg_id,
  input  logic   rd_mem_id,
  input  logic   wr_mem_id,
  input  logic   is_br_id,
  input  logic   is_jal_id,
  output logic   redirect,
  output word_t  target,
  output word_t  result_ex,
  output word_t  store_ex,
  output regno_t wregno_ex,
  output logic   wr_reg_ex,
  output logic   rd_mem_ex,
  output logic   wr_mem_ex
);

  localparam int SHAMT_BITS = $clog2($bits(word_t));

  logic signed [$bits(word_t)-1:0] a_s;
  logic signed [$bits(word_t)-1:0] b_s;
  logic [SHAMT_BITS-1:0]           shamt;
  word_t                           alu_result;
  word_t                           offset;
  logic                            br_taken;

  assign a_s   = a_id;
  assign b_s   = b_id;
  assign shamt = b_id[SHAMT_BITS-1:0];

  // ******************************************************************
  // ALU
  // ******************************************************************
  always_comb begin
    case (op1_id)
      OP1_ALUR: begin
        case (op2_id)
          OP2_EQ:   alu_result = word_t'(a_s == b_s);
          OP2_LT:   alu_result = word_t'(a_s < b_s);
          OP2_LE:   alu_result = word_t'(a_s <= b_s);
          OP2_NE:   alu_result = word_t'(a_s != b_s);
          OP2_ADD:  alu_result = a_id + b_id;
          OP2_AND:  alu_result = a_id & b_id;
          OP2_OR:   alu_result = a_id | b_id;
          OP2_XOR:  alu_result = a_id ^ b_id;
          OP2_SUB:  alu_result = a_id - b_id;
          OP2_NAND: alu_result = ~(a_id & b_id);
          OP2_NOR:  alu_result = ~(a_id | b_id);
          OP2_NXOR: alu_result = ~(a_id ^ b_id);
          OP2_RSHF: alu_result = a_id >> shamt;
          OP2_LSHF: alu_result = a_id << shamt;
          default:  alu_result = '0;
        endcase
      end
      // Address sum for memory ops shares the adder with ADDI
      OP1_LW, OP1_SW, OP1_ADDI: alu_result = a_id + imm_id;
      OP1_ANDI: alu_result = a_id & imm_id;
      OP1_ORI:  alu_result = a_id | imm_id;
      OP1_XORI: alu_result = a_id ^ imm_id;
      OP1_JAL:  alu_result = pc_id + INST_BYTES;
      default:  alu_result = '0;
    endcase
  end

  // ******************************************************************
  // Branch resolution
  // ******************************************************************
  always_comb begin
    case (op1_id)
      OP1_BEQ: br_taken = (a_s == b_s);
      OP1_BLT: br_taken = (a_s < b_s);
      OP1_BLE: br_taken = (a_s <= b_s);
      OP1_BNE: br_taken = (a_s != b_s);
      default: br_taken = 1'b0;
    endcase
  end

  // Immediate counts instructions
  assign offset   = imm_id << 2;
  assign target   = is_jal_id ? (a_id + offset) : (pc_id + INST_BYTES + offset);
  assign redirect = (is_br_id && br_taken) || is_jal_id;

  // ******************************************************************
  // Execute latch
  // ******************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wregno_ex <= '0;
      wr_reg_ex <= 1'b0;
      rd_mem_ex <= 1'b0;
      wr_mem_ex <= 1'b0;
    end else begin
      wregno_ex <= wregno_id;
      wr_reg_ex <= wr_reg_id;
      rd_mem_ex <= rd_mem_id;
      wr_mem_ex <= wr_mem_id;
    end
  end

  always_ff @(posedge clk) begin
    result_ex <= alu_result;
    store_ex  <= b_id;
  end

endmodule

//--- design/memory_stage.sv
module memory_stage
  import isa_pkg::*, cpu_cfg_pkg::*;
#(
  parameter int DMEM_WORDS = DMEM_WORDS_DEFAULT
) (
  input  logic   clk,
  input  logic   reset,
  input  word_t  result_ex,
  input  word_t  store_ex,
  input  regno_t wregno_ex,
  input  logic   wr_reg_ex,
  input  logic   rd_mem_ex,
  input  logic   wr_mem_ex,
  input  key_t   key,
  output hex_t   hex_value,
  output logic   hex_we,
  output logic   wb_we,
  output regno_t wb_regno,
  output word_t  wb_data
);

  localparam int INDEX_BITS = $clog2(DMEM_WORDS);
  localparam int BYTE_BITS  = $clog2($bits(word_t) / 8);

  word_t                 dmem [DMEM_WORDS];
  logic [INDEX_BITS-1:0] dmem_index;
  logic                  at_hex;
  logic                  at_key;
  word_t                 load_data;

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = '0;
    end
  end

  // Word address, wrapping over the memory depth
  assign dmem_index = result_ex[BYTE_BITS +: INDEX_BITS];

  assign at_hex = (result_ex == ADDR_HEX);
  assign at_key = (result_ex == ADDR_KEY);

  // ******************************************************************
  // Data memory and I/O
  // ******************************************************************
  always_ff @(posedge clk) begin
    if (wr_mem_ex && !at_hex && !at_key) begin
      dmem[dmem_index] <= store_ex;
    end
  end

  assign hex_we = wr_mem_ex && at_hex;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_value <= HEX_RESET;
    end else if (hex_we) begin
      hex_value <= store_ex[HEX_BITS-1:0];
    end
  end

  // Keys are active low on the board
  assign load_data = at_key ? {{($bits(word_t) - KEY_BITS){1'b0}}, ~key} : dmem[dmem_index];

  // ******************************************************************
  // Memory latch
  // ******************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_we    <= 1'b0;
      wb_regno <= '0;
    end else begin
      wb_we    <= wr_reg_ex;
      wb_regno <= wregno_ex;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= rd_mem_ex ? load_data : result_ex;
  end

endmodule

//--- design/cpu_top.sv
module cpu_top
  import isa_pkg::*, cpu_cfg_pkg::*;
#(
  parameter word_t START_PC   = START_PC_DEFAULT,
  parameter int    DMEM_WORDS = DMEM_WORDS_DEFAULT
) (
  input  logic  clk,
  input  logic  reset,
  output word_t imem_addr,
  input  inst_t imem_data,
  input  key_t  key,
  output hex_t  hex_value,
  output logic  hex_we
);

  // Fetch to decode
  inst_t  inst_fe;
  word_t  pc_fe;
  // Register file read side
  regno_t rs;
  regno_t rt;
  word_t  rs_val;
  word_t  rt_val;
  // Decode latch
  op1_t   op1_id;
  op2_t   op2_id;
  word_t  a_id;
  word_t  b_id;
  word_t  imm_id;
  word_t  pc_id;
  regno_t wregno_id;
  logic   wr_reg_id;
  logic   rd_mem_id;
  logic   wr_mem_id;
  logic   is_br_id;
  logic   is_jal_id;
  // Execute latch
  word_t  result_ex;
  word_t  store_ex;
  regno_t wregno_ex;
  logic   wr_reg_ex;
  logic   rd_mem_ex;
  logic   wr_mem_ex;
  // Write-back
  logic   wb_we;
  regno_t wb_regno;
  word_t  wb_data;
  // Pipeline control
  logic   stall;
  logic   redirect;
  word_t  target;

  fetch_stage #(
    .START_PC (START_PC)
  ) fetch_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .target    (target),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .inst_fe   (inst_fe),
    .pc_fe     (pc_fe)
  );

  decode_stage decode_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .inst_fe   (inst_fe),
    .pc_fe     (pc_fe),
    .rs        (rs),
    .rt        (rt),
    .rs_val    (rs_val),
    .rt_val    (rt_val),
    .op1_id    (op1_id),
    .op2_id    (op2_id),
    .a_id      (a_id),
    .b_id      (b_id),
    .imm_id    (imm_id),
    .pc_id     (pc_id),
    .wregno_id (wregno_id),
    .wr_reg_id (wr_reg_id),
    .rd_mem_id (rd_mem_id),
    .wr_mem_id (wr_mem_id),
    .is_br_id  (is_br_id),
    .is_jal_id (is_jal_id)
  );

  register_file register_file_inst (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .rs_val (rs_val),
    .rt_val (rt_val),
    .we     (wb_we),
    .wregno (wb_regno),
    .wdata  (wb_data)
  );

  hazard_unit hazard_unit_inst (
    .inst_fe   (inst_fe),
    .wregno_id (wregno_id),
    .wregno_ex (wregno_ex),
    .wr_reg_id (wr_reg_id),
    .wr_reg_ex (wr_reg_ex),
    .stall     (stall)
  );

  execute_stage execute_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .op1_id    (op1_id),
    .op2_id    (op2_id),
    .a_id      (a_id),
    .b_id      (b_id),
    .imm_id    (imm_id),
    .pc_id     (pc_id),
    .wregno_id (wregno_id),
    .wr_reg_id (wr_reg_id),
    .rd_mem_id (rd_mem_id),
    .wr_mem_id (wr_mem_id),
    .is_br_id  (is_br_id),
    .is_jal_id (is_jal_id),
    .redirect  (redirect),
    .target    (target),
    .result_ex (result_ex),
    .store_ex  (store_ex),
    .wregno_ex (wregno_ex),
    .wr_reg_ex (wr_reg_ex),
    .rd_mem_ex (rd_mem_ex),
    .wr_mem_ex (wr_mem_ex)
  );

  memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) memory_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .result_ex (result_ex),
    .store_ex  (store_ex),
    .wregno_ex (wregno_ex),
    .wr_reg_ex (wr_reg_ex),
    .rd_mem_ex (rd_mem_ex),
    .wr_mem_ex (wr_mem_ex),
    .key       (key),
    .hex_value (hex_value),
    .hex_we    (hex_we),
    .wb_we     (wb_we),
    .wb_regno  (wb_regno),
    .wb_data   (wb_data)
  );

endmodule

//--- verification/cpu_model.svh
// ********************************************************************
// Program memory and random program generator
// ********************************************************************
localparam int PROG_WORDS  = 128;
// Subroutine for the JAL tests, placed after the main program
localparam int BLOCK_INDEX = 96;
localparam int MODEL_STEPS = 4000;

localparam op2_t ALU_FUNCS [14] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND,
                                    OP2_OR, OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR,
                                    OP2_NXOR, OP2_RSHF, OP2_LSHF};
localparam op1_t IMM_OPS [4]    = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
localparam op1_t BRANCH_OPS [4] = '{OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};

inst_t  prog [PROG_WORDS];
int     prog_len;
integer seed;

// Reference state, data memory survives reset like the DUT's
word_t  ref_regs [16];
word_t  ref_dmem [DMEM_WORDS];
hex_t   expected_hex [$];
logic   model_ok;

function automatic inst_t inst_at(word_t addr);
  word_t offset;
  int    idx;
  offset = addr - START_PC;
  if (offset < PROG_WORDS * 4) begin
    idx = int'(offset >> 2);
    return prog[idx];
  end
  return INST_BUBBLE;
endfunction

function automatic inst_t r_format(op2_t op2, regno_t rd, regno_t rs, regno_t rt);
  return {OP1_ALUR, op2, 6'b000000, rd, rs, rt};
endfunction

function automatic inst_t i_format(op1_t op1, regno_t rs, regno_t rt, imm_t imm);
  return {op1, 2'b00, imm, rs, rt};
endfunction

function automatic int rand_below(int n);
  return int'($unsigned($random(seed)) % n);
endfunction

// r0 stays zero, r14 and r15 are link registers
function automatic regno_t pick_reg();
  return regno_t'(1 + rand_below(12));
endfunction

task automatic emit(inst_t inst);
  prog[prog_len] = inst;
  prog_len++;
endtask

task automatic clear_program();
  int i;
  for (i = 0; i < PROG_WORDS; i++) begin
    prog[i] = INST_BUBBLE;
  end
  prog_len = 0;
endtask

task automatic show(regno_t r);
  emit(i_format(OP1_SW, 4'd0, r, imm_t'(ADDR_HEX[15:0])));
endtask

// BEQ r0,r0,-1 branches to itself
task automatic end_program();
  emit(i_format(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
endtask

task automatic seed_registers();
  int r;
  for (r = 1; r <= 12; r++) begin
    emit(i_format(OP1_ADDI, 4'd0, regno_t'(r), imm_t'($random(seed))));
  end
endtask

// Mostly reads the previous result to keep the interlock busy
task automatic random_alu(inout regno_t last);
  regno_t dst;
  regno_t src_a;
  regno_t src_b;
  dst   = pick_reg();
  src_a = (rand_below(4) != 0) ? last : pick_reg();
  src_b = (rand_below(2) != 0) ? last : pick_reg();
  if (rand_below(2) == 0) begin
    emit(r_format(ALU_FUNCS[rand_below(14)], dst, src_a, src_b));
  end else begin
    emit(i_format(IMM_OPS[rand_below(4)], src_a, dst, imm_t'($random(seed))));
  end
  last = dst;
endtask

// ********************************************************************
// Instruction-level reference
// ********************************************************************
function automatic word_t alu_reference(op2_t op2, word_t a, word_t b);
  case (op2)
    OP2_EQ:   return (a == b) ? 32'd1 : 32'd0;
    OP2_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP2_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
    OP2_NE:   return (a != b) ? 32'd1 : 32'd0;
    OP2_ADD:  return a + b;
    OP2_AND:  return a & b;
    OP2_OR:   return a | b;
    OP2_XOR:  return a ^ b;
    OP2_SUB:  return a - b;
    OP2_NAND: return ~(a & b);
    OP2_NOR:  return ~(a | b);
    OP2_NXOR: return ~(a ^ b);
    OP2_RSHF: return a >> b[4:0];
    OP2_LSHF: return a << b[4:0];
    default:  return 32'd0;
  endcase
endfunction

task automatic run_model(key_t keys);
  word_t  pc;
  word_t  next_pc;
  word_t  a;
  word_t  b;
  word_t  imm;
  word_t  addr;
  inst_t  inst;
  op1_t   op1;
  op2_t   op2;
  regno_t rd;
  regno_t rs;
  regno_t rt;
  key_t   pressed;
  int     steps;
  int     r;
  for (r = 0; r < 16; r++) begin
    ref_regs[r] = 32'd0;
  end
  expected_hex.delete();
  pressed  = ~keys;
  pc       = START_PC;
  model_ok = 1'b0;
  steps    = 0;
  while (!model_ok && steps < MODEL_STEPS) begin
    inst    = inst_at(pc);
    op1     = inst[31:26];
    op2     = inst[25:18];
    rd      = inst[11:8];
    rs      = inst[7:4];
    rt      = inst[3:0];
    imm     = {{16{inst[23]}}, inst[23:8]};
    a       = ref_regs[rs];
    b       = ref_regs[rt];
    addr    = a + imm;
    next_pc = pc + 4;
    case (op1)
      OP1_ALUR: begin
        if (op2 != OP2_NOP) begin
          ref_regs[rd] = alu_reference(op2, a, b);
        end
      end
      OP1_ADDI: ref_regs[rt] = a + imm;
      OP1_ANDI: ref_regs[rt] = a & imm;
      OP1_ORI:  ref_regs[rt] = a | imm;
      OP1_XORI: ref_regs[rt] = a ^ imm;
      OP1_LW: begin
        if (addr == ADDR_KEY) begin
          ref_regs[rt] = word_t'(pressed);
        end else begin
          ref_regs[rt] = ref_dmem[int'((addr >> 2) % DMEM_WORDS)];
        end
      end
      OP1_SW: begin
        if (addr == ADDR_HEX) begin
          expected_hex.push_back(b[HEX_BITS-1:0]);
        end else if (addr != ADDR_KEY) begin
          ref_dmem[int'((addr >> 2) % DMEM_WORDS)] = b;
        end
      end
      OP1_BEQ: if (a == b) next_pc = pc + 4 + (imm << 2);
      OP1_BLT: if ($signed(a) < $signed(b)) next_pc = pc + 4 + (imm << 2);
      OP1_BLE: if ($signed(a) <= $signed(b)) next_pc = pc + 4 + (imm << 2);
      OP1_BNE: if (a != b) next_pc = pc + 4 + (imm << 2);
      OP1_JAL: begin
        next_pc      = a + (imm << 2);
        ref_regs[rt] = pc + 4;
      end
      default: ;
    endcase
    // A branch to itself ends the program
    if (next_pc == pc) begin
      model_ok = 1'b1;
    end
    pc = next_pc;
    steps++;
  end
endtask

//--- verification/cpu_tb.sv
module cpu_tb
  import isa_pkg::*, cpu_cfg_pkg::*;
();

  localparam word_t START_PC    = START_PC_DEFAULT;
  localparam int    DMEM_WORDS  = DMEM_WORDS_DEFAULT;
  localparam int    WAIT_CYCLES = 3000;
  localparam int    IDLE_CYCLES = 20;
  localparam int    ROUNDS      = 4;

  logic  clk;
  logic  reset;
  word_t imem_addr;
  inst_t imem_data;
  key_t  key;
  hex_t  hex_value;
  logic  hex_we;

  int    error_count;
  int    tests_run;
  int    tests_failed;
  int    round;

  `include "cpu_model.svh"

  cpu_top #(
    .START_PC   (START_PC),
    .DMEM_WORDS (DMEM_WORDS)
  ) cpu_top_inst (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .key       (key),
    .hex_value (hex_value),
    .hex_we    (hex_we)
  );

  // Instruction memory answers in the same cycle
  assign imem_data = inst_at(imem_addr);

  always #10 clk = ~clk;

  task automatic check_value(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic drive_idle();
    reset <= 1'b1;
    key   <= '0;
  endtask

  task automatic hold_reset();
    int n;
    for (n = 0; n < 3; n++) begin
      @(posedge clk);
    end
    reset <= 1'b0;
  endtask

  task automatic report_test(string name, int errors_before, int seen, int expected);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("%s: %0d of %0d display writes, %0d errors", name, seen, expected,
             error_count - errors_before);
  endtask

  // ******************************************************************
  // Program builders
  // ******************************************************************
  task automatic alu_chain_program();
    regno_t last;
    int     n;
    seed_registers();
    last = 4'd1;
    for (n = 0; n < 40; n++) begin
      random_alu(last);
      if (rand_below(3) == 0) begin
        show(last);
      end
    end
    show(last);
    end_program();
  endtask

  task automatic memory_program();
    regno_t last;
    regno_t r;
    imm_t   addr;
    int     n;
    seed_registers();
    last = 4'd1;
    for (n = 0; n < 16; n++) begin
      addr = imm_t'(rand_below(32) * 4);
      r    = pick_reg();
      case (rand_below(3))
        0: begin
          emit(i_format(OP1_SW, 4'd0, r, addr));
          random_alu(last);
        end
        1: begin
          emit(i_format(OP1_LW, 4'd0, r, addr));
          show(r);
        end
        default: begin
          // Store then load the same word back to back
          emit(i_format(OP1_SW, 4'd0, last, addr));
          emit(i_format(OP1_LW, 4'd0, r, addr));
          show(r);
        end
      endcase
    end
    end_program();
  endtask

  task automatic branch_program();
    regno_t last;
    regno_t rs;
    regno_t rt;
    int     skip;
    int     n;
    int     k;
    seed_registers();
    last = 4'd1;
    for (n = 0; n < 8; n++) begin
      if (n == 4) begin
        emit(i_format(OP1_JAL, 4'd0, 4'd14, imm_t'((START_PC + BLOCK_INDEX * 4) >> 2)));
      end
      rs   = (rand_below(2) == 0) ? last : pick_reg();
      rt   = (rand_below(3) == 0) ? rs : pick_reg();
      skip = 1 + rand_below(3);
      emit(i_format(BRANCH_OPS[rand_below(4)], rs, rt, imm_t'(skip)));
      for (k = 0; k < skip; k++) begin
        if (k % 2 == 0) begin
          random_alu(last);
        end else begin
          show(last);
        end
      end
      show(last);
    end
    end_program();
    // Subroutine, returns through r14
    prog_len = BLOCK_INDEX;
    for (k = 0; k < 4; k++) begin
      random_alu(last);
      show(last);
    end
    emit(i_format(OP1_JAL, 4'd14, 4'd15, 16'h0000));
  endtask

  task automatic key_program();
    regno_t last;
    regno_t r;
    int     n;
    for (n = 0; n < 6; n++) begin
      r = pick_reg();
      emit(i_format(OP1_LW, 4'd0, r, imm_t'(ADDR_KEY[15:0])));
      show(r);
      if (rand_below(2) == 0) begin
        last = r;
        random_alu(last);
        show(last);
      end
    end
    end_program();
  endtask

  // ******************************************************************
  // Test sequencing
  // ******************************************************************
  task automatic collect_display(string name, output int got);
    int   cycles;
    int   idle;
    int   extra;
    logic pending;
    got     = 0;
    idle    = 0;
    extra   = 0;
    pending = 1'b0;
    for (cycles = 0; cycles < WAIT_CYCLES && idle < IDLE_CYCLES; cycles++) begin
      @(negedge clk);
      // Display register has loaded at the edge after the strobe
      if (pending) begin
        if (got < expected_hex.size()) begin
          check_value("hex_value", word_t'(hex_value), word_t'(expected_hex[got]));
          got++;
        end else begin
          extra++;
        end
      end
      pending = hex_we;
      if (got >= expected_hex.size() && !pending) begin
        idle++;
      end else begin
        idle = 0;
      end
    end
    if (got < expected_hex.size()) begin
      $display("%s: timeout, %0d display writes still missing", name,
               expected_hex.size() - got);
      error_count++;
    end else if (extra > 0) begin
      $display("%s: %0d display writes beyond the expected ones", name, extra);
      error_count++;
    end
  endtask

  task automatic run_test(int kind, string name);
    key_t new_key;
    int   errors_before;
    int   got;
    errors_before = error_count;
    new_key       = key_t'($random(seed));
    @(posedge clk);
    reset <= 1'b1;
    key   <= new_key;
    clear_program();
    case (kind)
      0:       alu_chain_program();
      1:       memory_program();
      2:       branch_program();
      default: key_program();
    endcase
    run_model(new_key);
    hold_reset();
    if (!model_ok) begin
      $display("%s: reference program never reached its final loop", name);
      error_count++;
    end
    collect_display(name, got);
    report_test(name, errors_before, got, expected_hex.size());
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    check_value("hex_value", word_t'(hex_value), word_t'(HEX_RESET));
    check_value("hex_we", word_t'(hex_we), 32'd0);
    check_value("imem_addr", imem_addr, START_PC);
    report_test("reset state", errors_before, 0, 0);
  endtask

  initial begin
    clk          = 1'b0;
    seed         = 32'hd850_0050;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    drive_idle();
    for (round = 0; round < DMEM_WORDS; round++) begin
      ref_dmem[round] = 32'd0;
    end
    clear_program();
    end_program();
    hold_reset();
    check_reset_state();
    for (round = 0; round < ROUNDS; round++) begin
      run_test(0, $sformatf("alu chains %0d", round));
      run_test(1, $sformatf("data memory %0d", round));
      run_test(2, $sformatf("control flow %0d", round));
      run_test(3, $sformatf("key input %0d", round));
    end
    $display("%0d tests, %0d with errors, %0d errors in total", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+verification
design/isa_pkg.sv
design/cpu_cfg_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module cpu_tb -f all.f -o cpu_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
grep -q "test failed" sim.log && exit 1 || exit 0
